// File: flist.f
+incdir+include
verilog/acc_pkg.sv
verilog/acc_ctrl_fsm.sv
verilog/acc_row_counter.sv
verilog/acc_skew_line.sv
verilog/acc_bank_array.sv
verilog/acc_activation.sv
verilog/acc_top.sv
test/acc_tb.sv

// File: include/acc_tb_tasks.svh
`ifndef ACC_TB_TASKS_SVH
`define ACC_TB_TASKS_SVH

// 32-bit xorshift, stays nonzero for a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// counts every compare, one line per mismatch
task automatic check_value(input string what, input logic signed [31:0] exp_v,
                           input logic signed [31:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
        errors++;
        $display("FAILED %s expected %0d actual %0d", what, exp_v, act_v);
    end
endtask

// expected drained value from a stored sum
function automatic int shape_out(input acc_word_t v, input logic relu, input int shift);
    longint x;
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (OUT_W - 1)) - 1;
    lo = -hi - 1;
    x  = v;                  // sign extended
    if (relu && x < 0) begin
        x = 0;
    end
    x = x >>> shift;
    if (x > hi) begin
        x = hi;
    end else if (x < lo) begin
        x = lo;
    end
    return int'(x);
endfunction

// replay a write command on the bank model, drains leave it alone
task automatic apply_to_model(input acc_op_e op, input int base, input int rows);
    int a;
    for (int r = 0; r < rows; r++) begin
        a = (base + r) % DEPTH;   // wraps like the row counter
        for (int c = 0; c < N_COLS; c++) begin
            if (op == OP_OVERWRITE) begin
                ref_mem[c][a] = acc_word_t'(row_data[r][c]);
            end else if (op == OP_ACCUM) begin
                ref_mem[c][a] = ref_mem[c][a] + acc_word_t'(row_data[r][c]);
            end
        end
    end
endtask

`endif

// File: test/acc_tb.sv
module acc_tb
    import acc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_COLS       = 4;
    localparam int          DEPTH        = 16;
    localparam int          RESET_CYCLES = 4;
    localparam logic [31:0] SEED         = 32'haa02;

    logic                    clk_i;
    logic                    arst_n_i;
    logic                    start_i;
    acc_cmd_t                cmd_i;
    in_word_t  [N_COLS-1:0]  col_data_i;
    logic      [N_COLS-1:0]  out_valid_o;
    out_word_t [N_COLS-1:0]  out_data_o;
    logic                    busy_o;
    logic                    done_o;

    acc_cmd_t    t_cmd[$];    // one entry per data line
    string       t_name[$];
    logic [31:0] t_seed[$];
    in_word_t    row_data [DEPTH][N_COLS];
    acc_word_t   ref_mem [N_COLS][DEPTH];   // bank model
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycle_cnt   = 0;
    int          cycle_limit = RESET_CYCLES;

    `include "acc_tb_tasks.svh"

    acc_top #(.NUM_COLS(N_COLS), .DEPTH(DEPTH)) dut_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .cmd_i       (cmd_i),
        .col_data_i  (col_data_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic read_tests();
        int          fd;
        int          n;
        string       line;
        string       tname;
        string       oname;
        int          base;
        int          rows;
        int          relu;
        int          shift;
        logic [31:0] seed;
        acc_cmd_t    cmd;
        fd = $fopen("test/acc_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/acc_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                continue;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;   // blank or column notes
            end
            n = $sscanf(line, "%s %s %d %d %d %d %h", tname, oname, base, rows, relu, shift, seed);
            if (n != 7 || rows < 1 || rows > DEPTH) begin
                $display("ignoring a malformed test line: %s", line);
                errors++;
                continue;
            end
            case (oname)
                "overwrite": cmd.op = OP_OVERWRITE;
                "accum":     cmd.op = OP_ACCUM;
                "drain":     cmd.op = OP_DRAIN;
                default: begin
                    $display("unknown opcode %s in test %s", oname, tname);
                    errors++;
                    continue;
                end
            endcase
            cmd.base    = ADDR_W'(base);
            cmd.rows_m1 = ADDR_W'(rows - 1);
            cmd.relu    = (relu != 0);
            cmd.shift   = 5'(shift);
            t_cmd.push_back(cmd);
            t_name.push_back(tname);
            t_seed.push_back(seed);
            cycle_limit += rows + N_COLS + 10;
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int idx);
        acc_cmd_t cmd;
        int       rows;
        int       last;
        int       errs_before;
        int       r;
        logic     exp_valid;
        cmd         = t_cmd[idx];
        rows        = int'(cmd.rows_m1) + 1;
        last        = rows + N_COLS + 2;   // done cycle
        errs_before = errors;
        rng         = (t_seed[idx] == 0) ? SEED : t_seed[idx];
        for (int rr = 0; rr < rows; rr++) begin
            for (int c = 0; c < N_COLS; c++) begin
                rng = xorshift32(rng);
                row_data[rr][c] = in_word_t'($signed(rng[15:0]) >>> rng[19:16]);
            end
        end
        @(negedge clk_i);   // cycle 0
        check_value({t_name[idx], " busy_o before start"}, 0, busy_o);
        start_i = 1'b1;
        cmd_i   = cmd;
        for (int k = 1; k <= last; k++) begin
            @(negedge clk_i);
            start_i = (k == 2);   // strobe while busy, must be dropped
            if (k == 1) begin
                cmd_i.base    = cmd.base + 4'd3;
                cmd_i.rows_m1 = '1;
            end
            for (int c = 0; c < N_COLS; c++) begin
                r   = k - 1 - c;
                rng = xorshift32(rng);
                col_data_i[c] = (r >= 0 && r < rows) ? row_data[r][c] : in_word_t'(rng[15:0]);
                r         = k - 3 - c;   // drained row seen this cycle
                exp_valid = (cmd.op == OP_DRAIN) && r >= 0 && r < rows;
                if (out_valid_o[c] !== exp_valid) begin
                    errors++;
                    $display("test %s: %s output valid on column %0d at cycle %0d", t_name[idx],
                             exp_valid ? "missing" : "unexpected", c, k);
                end else if (exp_valid) begin
                    check_value($sformatf("%s col %0d row %0d", t_name[idx], c, r),
                                shape_out(ref_mem[c][(int'(cmd.base) + r) % DEPTH],
                                          cmd.relu, cmd.shift),
                                out_data_o[c]);
                end
            end
            check_value($sformatf("%s done_o cycle %0d", t_name[idx], k), k == last, done_o);
            check_value($sformatf("%s busy_o cycle %0d", t_name[idx], k), 1, busy_o);
        end
        apply_to_model(cmd.op, int'(cmd.base), rows);
        $display("test %-14s finished with %0d errors", t_name[idx], errors - errs_before);
    endtask

    initial begin
        arst_n_i   = 1'b0;
        start_i    = 1'b0;
        cmd_i      = '0;
        col_data_i = '0;
        errors     = 0;
        checks     = 0;
        read_tests();
        if (t_cmd.size() == 0) begin
            errors++;
            $display("no usable test lines were found in the data file");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk_i);
            @(negedge clk_i);
            arst_n_i = 1'b1;
            repeat (3) begin
                @(negedge clk_i);
                check_value("after reset out_valid_o", 0, out_valid_o);
                check_value("after reset busy_o", 0, busy_o);
                check_value("after reset done_o", 0, done_o);
            end
            foreach (t_cmd[i]) begin
                run_test(i);
            end
        end
        $display("%0d tests, %0d checks, %0d errors", t_cmd.size(), checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: test/acc_testdata.txt
# name op base rows relu shift seed, seed in hex
# op is overwrite, accum or drain, a seed of 0 selects the default seed
fill_all        overwrite  0   16  0  0  0
drain_raw       drain      0   16  0  0  0
acc_first       accum      2   8   0  0  1f3d
acc_second      accum      2   8   0  0  7c21
drain_sum       drain      2   8   0  0  0
drain_sum_sh4   drain      2   8   0  4  0
relu_sh0        drain      0   16  1  0  0
relu_sh1        drain      0   16  1  1  0
plain_sh2       drain      0   16  0  2  0
relu_sh3        drain      0   16  1  3  0
plain_sh4       drain      0   16  0  4  0
relu_sh5        drain      0   16  1  5  0
plain_sh6       drain      0   16  0  6  0
relu_sh7        drain      0   16  1  7  0
plain_sh8       drain      0   16  0  8  0
relu_sh8        drain      0   16  1  8  0
wrap_fill       overwrite  13  6   0  0  51ab
wrap_drain      drain      13  6   0  0  0
wrap_drain_sh5  drain      13  6   1  5  0
rest_intact     drain      3   10  0  6  0
one_row_acc     accum      15  1   0  0  0e0e
one_row_drain   drain      15  1   0  0  0
wrap_acc        accum      10  16  0  0  3344
full_drain      drain      0   16  0  1  0
full_relu_sh8   drain      0   16  1  8  0

// File: verilog/acc_activation.sv
module acc_activation
    import acc_pkg::*;
#(
    parameter int NUM_COLS = acc_pkg::NUM_COLS
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic      [NUM_COLS-1:0]  valid_i,
    input  acc_word_t [NUM_COLS-1:0]  data_i,
    input  logic                      relu_i,
    input  logic      [4:0]           shift_i,
    output logic      [NUM_COLS-1:0]  valid_o,
    output out_word_t [NUM_COLS-1:0]  data_o
);

    localparam acc_word_t SAT_MAX = acc_word_t'((2 ** (OUT_W - 1)) - 1);
    localparam acc_word_t SAT_MIN = -acc_word_t'(2 ** (OUT_W - 1));

    logic [NUM_COLS-1:0] valid_q;

    generate
        for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
            acc_word_t clamped;
            acc_word_t shifted;
            out_word_t sat;
            out_word_t data_q;

            always_comb begin
                clamped = (relu_i && data_i[c][ACC_W-1]) ? '0 : data_i[c];   // relu
                shifted = clamped >>> shift_i;
                if (shifted > SAT_MAX) begin
                    sat = SAT_MAX[OUT_W-1:0];
                end else if (shifted < SAT_MIN) begin
                    sat = SAT_MIN[OUT_W-1:0];
                end else begin
                    sat = shifted[OUT_W-1:0];
                end
            end

            always_ff @(posedge clk_i) begin
                data_q <= sat;   // payload only
            end

            assign data_o[c] = data_q;
        end
    endgenerate

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_i;
        end
    end

    assign valid_o = valid_q;

endmodule

// File: verilog/acc_bank_array.sv
module acc_bank_array
    import acc_pkg::*;
#(
    parameter int NUM_COLS = acc_pkg::NUM_COLS,
    parameter int DEPTH    = ACC_DEPTH
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  acc_lane_t [NUM_COLS-1:0]      lanes_i,
    input  in_word_t  [NUM_COLS-1:0]      col_data_i,
    output logic      [NUM_COLS-1:0]      rd_valid_o,
    output acc_word_t [NUM_COLS-1:0]      rd_data_o
);

    generate
        for (genvar c = 0; c < NUM_COLS; c++) begin : g_bank
            acc_word_t mem [DEPTH];
            acc_word_t stored;
            acc_word_t ext;
            acc_word_t rd_q;
            logic      rd_valid_q;

            // async read so accumulate finishes in one cycle
            always_comb begin
                stored = mem[lanes_i[c].addr];
                ext    = {{(ACC_W - IN_W){col_data_i[c][IN_W-1]}}, col_data_i[c]};
            end

            always_ff @(posedge clk_i) begin
                if (lanes_i[c].valid) begin
                    case (lanes_i[c].op)
                        OP_OVERWRITE: mem[lanes_i[c].addr] <= ext;
                        OP_ACCUM:     mem[lanes_i[c].addr] <= stored + ext;
                        OP_DRAIN:     rd_q <= stored;
                        default: ;
                    endcase
                end
            end

            always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    rd_valid_q <= 1'b0;
                end else begin
                    rd_valid_q <= lanes_i[c].valid && (lanes_i[c].op == OP_DRAIN);
                end
            end

            assign rd_data_o[c]  = rd_q;
            assign rd_valid_o[c] = rd_valid_q;
        end
    endgenerate

endmodule

// File: verilog/acc_ctrl_fsm.sv
module acc_ctrl_fsm
    import acc_pkg::*;
(
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  acc_cmd_t          cmd_i,
    input  logic [ADDR_W-1:0] addr_i,        // current row from the counter
    input  logic              last_row_i,
    input  logic              flush_done_i,
    output logic              cnt_load_o,
    output logic              cnt_step_o,
    output logic              flush_start_o,
    output acc_lane_t         lane_o,
    output acc_cmd_t          cmd_q_o,
    output logic              busy_o,
    output logic              done_o
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        FLUSH = 2'd2
    } state_e;

    state_e   state_q;
    state_e   state_d;
    acc_cmd_t cmd_q;
    logic     accept;

    assign accept = (state_q == IDLE) && start_i;   // strobes while busy are dropped

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (last_row_i) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                // let the skew line and the read pipeline empty out
                if (flush_done_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cmd_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                cmd_q <= cmd_i;
            end
        end
    end

    assign cnt_load_o    = accept;
    assign cnt_step_o    = (state_q == RUN);
    assign flush_start_o = (state_q == RUN) && last_row_i;

    // one lane per run cycle, column 0 timing
    assign lane_o.valid = (state_q == RUN);
    assign lane_o.op    = cmd_q.op;
    assign lane_o.addr  = addr_i;

    assign cmd_q_o = cmd_q;
    assign busy_o  = (state_q != IDLE);
    assign done_o  = (state_q == FLUSH) && flush_done_i;   // last flush cycle

endmodule

// File: verilog/acc_pkg.sv
package acc_pkg;

    // array geometry defaults, overridden from the top level
    localparam int NUM_COLS  = 4;
    localparam int ACC_DEPTH = 16;

    localparam int IN_W   = 16;   // systolic partial sum
    localparam int ACC_W  = 24;   // accumulator word
    localparam int OUT_W  = 8;    // drained activation
    localparam int ADDR_W = 4;

    typedef enum logic [1:0] {
        OP_OVERWRITE = 2'd0,
        OP_ACCUM     = 2'd1,
        OP_DRAIN     = 2'd2
    } acc_op_e;

    typedef struct packed {
        acc_op_e             op;
        logic [ADDR_W-1:0]   base;
        logic [ADDR_W-1:0]   rows_m1;   // row count minus one
        logic                relu;
        logic [4:0]          shift;     // arithmetic right shift on drain
    } acc_cmd_t;

    // control word that walks across the columns with the data skew
    typedef struct packed {
        logic                valid;
        acc_op_e             op;
        logic [ADDR_W-1:0]   addr;
    } acc_lane_t;

    typedef logic signed [IN_W-1:0]  in_word_t;
    typedef logic signed [ACC_W-1:0] acc_word_t;
    typedef logic signed [OUT_W-1:0] out_word_t;

endpackage

// File: verilog/acc_row_counter.sv
module acc_row_counter
    import acc_pkg::*;
#(
    parameter int DEPTH    = ACC_DEPTH,
    parameter int NUM_COLS = acc_pkg::NUM_COLS
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              load_i,
    input  logic              step_i,
    input  logic              flush_start_i,
    input  logic [ADDR_W-1:0] base_i,
    input  logic [ADDR_W-1:0] rows_m1_i,
    output logic [ADDR_W-1:0] addr_o,
    output logic              last_row_o,
    output logic              flush_done_o
);

    localparam int FLUSH_LEN = NUM_COLS + 2;
    localparam int TMR_W     = $clog2(FLUSH_LEN);

    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] remain_q;   // rows left after the current one
    logic [TMR_W-1:0]  flush_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q   <= '0;
            remain_q <= '0;
        end else if (load_i) begin
            addr_q   <= base_i;
            remain_q <= rows_m1_i;
        end else if (step_i) begin
            // wrap at bank depth
            addr_q   <= (addr_q == ADDR_W'(DEPTH - 1)) ? '0 : addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

    // loaded in the last run cycle, so it hits zero on the last flush cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flush_q <= '0;
        end else if (flush_start_i) begin
            flush_q <= TMR_W'(FLUSH_LEN - 1);
        end else if (flush_q != '0) begin
            flush_q <= flush_q - 1'b1;
        end
    end

    assign addr_o       = addr_q;
    assign last_row_o   = (remain_q == '0);
    assign flush_done_o = (flush_q == '0);

endmodule

// File: verilog/acc_skew_line.sv
module acc_skew_line #(
    parameter type lane_t   = logic,
    parameter int  NUM_COLS = 4
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  lane_t                 lane_i,
    output lane_t [NUM_COLS-1:0]  lanes_o
);

    // column 0 sees the lane as issued
    assign lanes_o[0] = lane_i;

    generate
        if (NUM_COLS > 1) begin : g_stages
            lane_t [NUM_COLS-2:0] stage_q;

            // free running, so a flush pushes out the tail of a command
            always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    stage_q <= '0;   // all lanes invalid
                end else begin
                    stage_q[0] <= lane_i;
                    for (int i = 1; i < NUM_COLS - 1; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            for (genvar c = 1; c < NUM_COLS; c++) begin : g_tap
                assign lanes_o[c] = stage_q[c-1];   // c cycles late
            end
        end
    endgenerate

endmodule

// File: verilog/acc_top.sv
module acc_top
    import acc_pkg::*;
#(
    parameter int NUM_COLS = acc_pkg::NUM_COLS,
    parameter int DEPTH    = ACC_DEPTH
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      start_i,
    input  acc_cmd_t                  cmd_i,
    input  in_word_t  [NUM_COLS-1:0]  col_data_i,
    output logic      [NUM_COLS-1:0]  out_valid_o,
    output out_word_t [NUM_COLS-1:0]  out_data_o,
    output logic                      busy_o,
    output logic                      done_o
);

    logic                       cnt_load;
    logic                       cnt_step;
    logic                       flush_start;
    logic                       last_row;
    logic                       flush_done;
    logic [ADDR_W-1:0]          row_addr;
    acc_lane_t                  lane;
    acc_cmd_t                   cmd_q;
    acc_lane_t [NUM_COLS-1:0]   lanes;
    logic [NUM_COLS-1:0]        rd_valid;
    acc_word_t [NUM_COLS-1:0]   rd_data;

    acc_ctrl_fsm ctrl_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .start_i       (start_i),
        .cmd_i         (cmd_i),
        .addr_i        (row_addr),
        .last_row_i    (last_row),
        .flush_done_i  (flush_done),
        .cnt_load_o    (cnt_load),
        .cnt_step_o    (cnt_step),
        .flush_start_o (flush_start),
        .lane_o        (lane),
        .cmd_q_o       (cmd_q),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    // loaded on the start strobe, same edge that latches the command
    acc_row_counter #(.DEPTH(DEPTH), .NUM_COLS(NUM_COLS)) cnt_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .load_i        (cnt_load),
        .step_i        (cnt_step),
        .flush_start_i (flush_start),
        .base_i        (cmd_i.base),
        .rows_m1_i     (cmd_i.rows_m1),
        .addr_o        (row_addr),
        .last_row_o    (last_row),
        .flush_done_o  (flush_done)
    );

    // row address follows the systolic column skew
    acc_skew_line #(.lane_t(acc_lane_t), .NUM_COLS(NUM_COLS)) skew_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .lane_i   (lane),
        .lanes_o  (lanes)
    );

    acc_bank_array #(.NUM_COLS(NUM_COLS), .DEPTH(DEPTH)) banks_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .lanes_i    (lanes),
        .col_data_i (col_data_i),
        .rd_valid_o (rd_valid),
        .rd_data_o  (rd_data)
    );

    acc_activation #(.NUM_COLS(NUM_COLS)) act_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (rd_valid),
        .data_i   (rd_data),
        .relu_i   (cmd_q.relu),
        .shift_i  (cmd_q.shift),
        .valid_o  (out_valid_o),
        .data_o   (out_data_o)
    );

endmodule
